/* rv_front_pkg.sv */
// shared widths, opcodes and cause codes for the fetch/decode/allocate front end
package rv_front_pkg;

  typedef logic [31:0] word_t;
  // byte address, bit 1 set means misaligned
  typedef logic [31:0] pc_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [4:0]  reg_idx_t;
  // msb set when no register is written
  typedef logic [5:0]  rd_tag_t;
  typedef logic [4:0]  rsop_t;
  typedef logic [6:0]  retop_t;
  typedef logic [1:0]  ecause_t;

  localparam ecause_t ERR_IALIGN   = 2'd0;
  localparam ecause_t ERR_IFAULT   = 2'd1;
  localparam ecause_t ERR_IILLEGAL = 2'd2;

  // implemented major opcodes, everything else decodes as illegal
  localparam opcode_t OPC_LOAD    = 5'b00000;
  localparam opcode_t OPC_MISCMEM = 5'b00011;
  localparam opcode_t OPC_OPIMM   = 5'b00100;
  localparam opcode_t OPC_AUIPC   = 5'b00101;
  localparam opcode_t OPC_STORE   = 5'b01000;
  localparam opcode_t OPC_OP      = 5'b01100;
  localparam opcode_t OPC_LUI     = 5'b01101;
  localparam opcode_t OPC_BRANCH  = 5'b11000;
  localparam opcode_t OPC_JALR    = 5'b11001;
  localparam opcode_t OPC_JAL     = 5'b11011;
  localparam opcode_t OPC_SYSTEM  = 5'b11100;

  localparam int ROB_DEPTH = 16;
  localparam int ROB_ID_W  = $clog2(ROB_DEPTH);

  typedef logic [ROB_ID_W-1:0] robid_t;
  // one extra bit so a completely full buffer can be counted
  typedef logic [ROB_ID_W:0]   robcnt_t;

  localparam robcnt_t ROB_FULL_CNT = robcnt_t'(ROB_DEPTH);

  localparam pc_t RESET_PC = 32'h0000_0000;

endpackage

/* front_ctrl.sv */
// flush sequencer: drains the open bus cycle, kills wrong-path work, reloads the pc
`timescale 1ns/100ps

module front_ctrl (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             flush_i,
  input  rv_front_pkg::pc_t flush_target_i,
  input  logic             bus_busy_i,
  input  logic             bus_done_i,
  output logic             kill_o,
  output logic             pc_load_o,
  output rv_front_pkg::pc_t pc_target_o,
  output logic             alloc_clear_o
);
  import rv_front_pkg::*;

  typedef enum logic [1:0] {
    ST_RUN,
    ST_DRAIN,
    ST_REDIRECT
  } state_t;

  state_t state_q;
  pc_t    target_q;

  // a new flush in redirect holds off the reload one more cycle
  assign pc_load_o     = (state_q == ST_REDIRECT) && !flush_i;
  assign alloc_clear_o = pc_load_o;
  assign pc_target_o   = target_q;
  assign kill_o        = flush_i || (state_q != ST_RUN);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_RUN;
    end else begin
      case (state_q)
        ST_RUN: begin
          if (flush_i) begin
            state_q <= (bus_busy_i && !bus_done_i) ? ST_DRAIN : ST_REDIRECT;
          end
        end
        ST_DRAIN: begin
          if (bus_done_i) begin
            state_q <= ST_REDIRECT;
          end
        end
        ST_REDIRECT: begin
          if (!flush_i) begin
            state_q <= ST_RUN;
          end
        end
        default: state_q <= ST_RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (flush_i) begin
      target_q <= flush_target_i;
    end
  end

endmodule

/* insn_fetch.sv */
// instruction fetch: pc, wishbone classic read cycle and one-entry buffer to decode
`timescale 1ns/100ps

module insn_fetch (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               kill_i,
  input  logic               pc_load_i,
  input  rv_front_pkg::pc_t   pc_target_i,
  input  logic               decode_stall_i,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output rv_front_pkg::pc_t   wb_adr_o,
  input  rv_front_pkg::word_t wb_dat_i,
  input  logic               wb_ack_i,
  input  logic               wb_err_i,
  output logic               bus_busy_o,
  output logic               bus_done_o,
  output logic               fetch_valid_o,
  output logic               fetch_error_o,
  output rv_front_pkg::pc_t   fetch_addr_o,
  output rv_front_pkg::word_t fetch_insn_o
);
  import rv_front_pkg::*;

  pc_t   pc_q;
  logic  cyc_q;
  logic  halt_q;
  logic  buf_valid_q;
  logic  buf_error_q;
  pc_t   buf_addr_q;
  word_t buf_insn_q;

  logic buf_take;
  logic can_start;
  logic start_bus;
  logic align_err;
  logic resp_keep;
  logic buf_load;

  assign bus_done_o = cyc_q && (wb_ack_i || wb_err_i);
  assign bus_busy_o = cyc_q;
  assign buf_take   = buf_valid_q && !decode_stall_i;
  // issue only into an empty buffer, or one being drained this cycle
  assign can_start  = !cyc_q && !halt_q && !kill_i && (!buf_valid_q || buf_take);
  assign start_bus  = can_start && !pc_q[1];
  assign align_err  = can_start && pc_q[1];
  assign resp_keep  = bus_done_o && !kill_i;
  assign buf_load   = resp_keep || align_err;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = pc_q;

  assign fetch_valid_o = buf_valid_q;
  assign fetch_error_o = buf_error_q;
  assign fetch_addr_o  = buf_addr_q;
  assign fetch_insn_o  = buf_insn_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q        <= RESET_PC;
      cyc_q       <= 1'b0;
      halt_q      <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (buf_take) begin
        buf_valid_q <= 1'b0;
      end
      if (bus_done_o) begin
        cyc_q <= 1'b0;
        if (resp_keep) begin
          buf_valid_q <= 1'b1;
          halt_q      <= wb_err_i;
          if (!wb_err_i) begin
            pc_q <= pc_q + 32'd4;
          end
        end
      end else if (start_bus) begin
        cyc_q <= 1'b1;
      end else if (align_err) begin
        buf_valid_q <= 1'b1;
        halt_q      <= 1'b1;
      end
      if (kill_i) begin
        buf_valid_q <= 1'b0;
      end
      // redirect starts the first read at once when the target is aligned
      if (pc_load_i) begin
        pc_q   <= pc_target_i;
        halt_q <= 1'b0;
        cyc_q  <= !pc_target_i[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (buf_load) begin
      buf_error_q <= align_err || wb_err_i;
      buf_addr_q  <= pc_q;
      buf_insn_q  <= wb_dat_i;
    end
  end

endmodule

/* insn_decode.sv */
// RV32I decoder: instruction register plus combinational field decode for rename and ROB
`timescale 1ns/100ps

module insn_decode (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  kill_i,
  input  logic                  fetch_valid_i,
  input  logic                  fetch_error_i,
  input  rv_front_pkg::pc_t      fetch_addr_i,
  input  rv_front_pkg::word_t    fetch_insn_i,
  output logic                  decode_stall_o,
  input  logic                  rob_full_i,
  input  logic                  rename_stall_i,
  output logic                  rob_valid_o,
  output logic                  rename_valid_o,
  output logic                  error_o,
  output rv_front_pkg::ecause_t  ecause_o,
  output rv_front_pkg::retop_t   retop_o,
  output rv_front_pkg::pc_t      addr_o,
  output rv_front_pkg::pc_t      target_o,
  output rv_front_pkg::rd_tag_t  rd_o,
  output rv_front_pkg::rsop_t    rsop_o,
  output rv_front_pkg::reg_idx_t rs1_o,
  output rv_front_pkg::reg_idx_t rs2_o,
  output rv_front_pkg::word_t    imm_o,
  output logic                  uses_rs1_o,
  output logic                  uses_rs2_o,
  output logic                  uses_imm_o,
  output logic                  uses_memory_o,
  output logic                  uses_pc_o,
  output logic                  csr_access_o
);
  import rv_front_pkg::*;

  logic  valid_q;
  logic  error_q;
  pc_t   addr_q;
  word_t insn_q;

  logic fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_inv;
  word_t   imm;
  rsop_t   rsop;
  opcode_t opcode;
  logic [2:0] funct3;
  logic [2:0] brop;
  logic insn_load, insn_jalr, insn_auipc, insn_csr, insn_complex;
  logic uses_rd;

  assign opcode = insn_q[6:2];
  assign funct3 = insn_q[14:12];

  assign insn_load  = (opcode == OPC_LOAD);
  assign insn_jalr  = (opcode == OPC_JALR);
  assign insn_auipc = (opcode == OPC_AUIPC);
  assign insn_csr   = (opcode == OPC_SYSTEM) && (funct3[1:0] != 2'b00);
  // M extension ops travel on the complex unit encoding
  assign insn_complex = fmt_r && insn_q[25];
  assign brop = {~|funct3[2:1], funct3[2:1]};

  assign uses_rd    = (fmt_r || fmt_i || fmt_u || fmt_j) && (insn_q[11:7] != 5'd0);
  assign uses_rs1_o = fmt_r || (fmt_i && (!insn_csr || !funct3[2])) || fmt_s || fmt_b;
  assign uses_rs2_o = fmt_r || fmt_s || fmt_b;
  assign uses_imm_o = !fmt_r && !fmt_b;
  assign uses_memory_o = insn_load || fmt_s;
  assign uses_pc_o     = fmt_j || insn_jalr || insn_auipc;
  assign csr_access_o  = insn_csr;

  assign decode_stall_o = rob_full_i || rename_stall_i;
  assign rob_valid_o    = valid_q && !rename_stall_i;
  assign error_o        = error_q || fmt_inv;
  assign rename_valid_o = valid_q && !error_o && !rob_full_i;
  assign ecause_o = error_q ? (addr_q[1] ? ERR_IALIGN : ERR_IFAULT) : ERR_IILLEGAL;
  assign retop_o  = {fmt_b, funct3[0], insn_jalr, fmt_s, funct3};

  assign addr_o   = addr_q;
  assign target_o = addr_q + imm;
  assign rd_o     = {!uses_rd, insn_q[11:7]};
  assign rsop_o   = rsop;
  assign rs1_o    = insn_q[19:15];
  assign rs2_o    = insn_q[24:20];
  assign imm_o    = imm;

  always_ff @(posedge clk) begin
    if (rst_i || kill_i) begin
      valid_q <= 1'b0;
    end else if (!decode_stall_o) begin
      valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!decode_stall_o && fetch_valid_i) begin
      error_q <= fetch_error_i;
      addr_q  <= fetch_addr_i;
      insn_q  <= fetch_insn_i;
    end
  end

  // format select, non-32-bit encodings are illegal
  always_comb begin
    {fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_inv} = 7'b0;
    if (insn_q[1:0] != 2'b11) begin
      fmt_inv = 1'b1;
    end else begin
      case (opcode)
        OPC_OP:      fmt_r = 1'b1;
        OPC_OPIMM,
        OPC_LOAD,
        OPC_JALR,
        OPC_MISCMEM,
        OPC_SYSTEM:  fmt_i = 1'b1;
        OPC_LUI,
        OPC_AUIPC:   fmt_u = 1'b1;
        OPC_STORE:   fmt_s = 1'b1;
        OPC_BRANCH:  fmt_b = 1'b1;
        OPC_JAL:     fmt_j = 1'b1;
        default:     fmt_inv = 1'b1;
      endcase
    end
  end

  always_comb begin
    imm = 32'd0;
    case (1'b1)
      fmt_i: imm = {{20{insn_q[31]}}, insn_q[31:20]};
      fmt_s: imm = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
      fmt_b: imm = {{20{insn_q[31]}}, insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};
      fmt_u: imm = {insn_q[31:12], 12'd0};
      fmt_j: imm = {{12{insn_q[31]}}, insn_q[19:12], insn_q[20], insn_q[30:21], 1'b0};
      default: imm = 32'd0;
    endcase
  end

  always_comb begin
    case (1'b1)
      uses_memory_o: rsop = {1'b0, fmt_s, funct3};
      insn_complex:  rsop = {2'b11, funct3};
      insn_jalr:     rsop = 5'b10000;
      fmt_b:         rsop = {2'b01, brop};
      // bit 30 picks sub/sra, only shifts among the immediates
      default:       rsop = {1'b0, (fmt_r || (funct3 == 3'b101)) && insn_q[30], funct3};
    endcase
  end

endmodule

/* rob_alloc.sv */
// reorder buffer id allocator: ring pointer plus occupancy count with full flag
`timescale 1ns/100ps

module rob_alloc (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 alloc_clear_i,
  input  logic                 rob_valid_i,
  input  logic                 retire_i,
  output logic                 rob_full_o,
  output rv_front_pkg::robid_t robid_o
);
  import rv_front_pkg::*;

  robid_t  ptr_q;
  robcnt_t count_q;
  logic    accept;

  assign rob_full_o = (count_q == ROB_FULL_CNT);
  assign accept     = rob_valid_i && !rob_full_o;
  assign robid_o    = ptr_q;

  always_ff @(posedge clk) begin
    if (rst_i || alloc_clear_i) begin
      ptr_q   <= '0;
      count_q <= '0;
    end else begin
      // pointer wraps naturally at the id width
      if (accept) begin
        ptr_q <= ptr_q + 1'b1;
      end
      case ({accept, retire_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* rv_front_top.sv */
// front end top: connects flush control, fetch, decode and id allocation
`timescale 1ns/100ps

module rv_front_top (
  input  logic                   clk,
  input  logic                   rst_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output rv_front_pkg::pc_t       wb_adr_o,
  input  rv_front_pkg::word_t     wb_dat_i,
  input  logic                   wb_ack_i,
  input  logic                   wb_err_i,
  input  logic                   flush_i,
  input  rv_front_pkg::pc_t       flush_target_i,
  input  logic                   retire_i,
  input  logic                   rename_stall_i,
  output logic                   rob_full_o,
  output rv_front_pkg::robid_t    robid_o,
  output logic                   rob_valid_o,
  output logic                   rename_valid_o,
  output logic                   error_o,
  output rv_front_pkg::ecause_t   ecause_o,
  output rv_front_pkg::retop_t    retop_o,
  output rv_front_pkg::pc_t       addr_o,
  output rv_front_pkg::pc_t       target_o,
  output rv_front_pkg::rd_tag_t   rd_o,
  output rv_front_pkg::rsop_t     rsop_o,
  output rv_front_pkg::reg_idx_t  rs1_o,
  output rv_front_pkg::reg_idx_t  rs2_o,
  output rv_front_pkg::word_t     imm_o,
  output logic                   uses_rs1_o,
  output logic                   uses_rs2_o,
  output logic                   uses_imm_o,
  output logic                   uses_memory_o,
  output logic                   uses_pc_o,
  output logic                   csr_access_o
);
  import rv_front_pkg::*;

  logic  kill;
  logic  pc_load;
  pc_t   pc_target;
  logic  alloc_clear;
  logic  bus_busy;
  logic  bus_done;
  logic  fetch_valid;
  logic  fetch_error;
  pc_t   fetch_addr;
  word_t fetch_insn;
  logic  decode_stall;

  front_ctrl front_ctrl_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .flush_i        (flush_i),
    .flush_target_i (flush_target_i),
    .bus_busy_i     (bus_busy),
    .bus_done_i     (bus_done),
    .kill_o         (kill),
    .pc_load_o      (pc_load),
    .pc_target_o    (pc_target),
    .alloc_clear_o  (alloc_clear)
  );

  insn_fetch insn_fetch_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .kill_i         (kill),
    .pc_load_i      (pc_load),
    .pc_target_i    (pc_target),
    .decode_stall_i (decode_stall),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_adr_o       (wb_adr_o),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_i       (wb_ack_i),
    .wb_err_i       (wb_err_i),
    .bus_busy_o     (bus_busy),
    .bus_done_o     (bus_done),
    .fetch_valid_o  (fetch_valid),
    .fetch_error_o  (fetch_error),
    .fetch_addr_o   (fetch_addr),
    .fetch_insn_o   (fetch_insn)
  );

  insn_decode insn_decode_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .kill_i         (kill),
    .fetch_valid_i  (fetch_valid),
    .fetch_error_i  (fetch_error),
    .fetch_addr_i   (fetch_addr),
    .fetch_insn_i   (fetch_insn),
    .decode_stall_o (decode_stall),
    .rob_full_i     (rob_full_o),
    .rename_stall_i (rename_stall_i),
    .rob_valid_o    (rob_valid_o),
    .rename_valid_o (rename_valid_o),
    .error_o        (error_o),
    .ecause_o       (ecause_o),
    .retop_o        (retop_o),
    .addr_o         (addr_o),
    .target_o       (target_o),
    .rd_o           (rd_o),
    .rsop_o         (rsop_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .imm_o          (imm_o),
    .uses_rs1_o     (uses_rs1_o),
    .uses_rs2_o     (uses_rs2_o),
    .uses_imm_o     (uses_imm_o),
    .uses_memory_o  (uses_memory_o),
    .uses_pc_o      (uses_pc_o),
    .csr_access_o   (csr_access_o)
  );

  rob_alloc rob_alloc_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .alloc_clear_i  (alloc_clear),
    .rob_valid_i    (rob_valid_o),
    .retire_i       (retire_i),
    .rob_full_o     (rob_full_o),
    .robid_o        (robid_o)
  );

endmodule

/* rv_front_sva.sv */
// protocol checks for the front end, bound into the top level by the testbench build
`timescale 1ns/100ps

module rv_front_sva (
  input logic                   clk,
  input logic                   rst_i,
  input logic                   wb_cyc_o,
  input logic                   wb_stb_o,
  input rv_front_pkg::pc_t      wb_adr_o,
  input logic                   wb_ack_i,
  input logic                   wb_err_i,
  input logic                   rename_stall_i,
  input logic                   rename_valid_o,
  input rv_front_pkg::pc_t      addr_o,
  input rv_front_pkg::word_t    imm_o,
  input rv_front_pkg::rd_tag_t  rd_o,
  input rv_front_pkg::rsop_t    rsop_o
);
  import rv_front_pkg::*;

  // open cycle keeps its strobe and address until answered
  assert property (@(posedge clk) disable iff (rst_i)
    wb_cyc_o && !(wb_ack_i || wb_err_i) |=> wb_cyc_o && wb_stb_o && $stable(wb_adr_o))
    else $error("wishbone address or strobe changed while waiting");

  // an answered cycle drops strobe and cycle for at least one clock
  assert property (@(posedge clk) disable iff (rst_i)
    wb_cyc_o && (wb_ack_i || wb_err_i) |=> !wb_cyc_o && !wb_stb_o)
    else $error("cycle or strobe still high after ack or err");

  assert property (@(posedge clk) disable iff (rst_i)
    rename_stall_i && rename_valid_o |=> $stable(addr_o) && $stable(imm_o)
      && $stable(rd_o) && $stable(rsop_o))
    else $error("decode outputs changed under rename stall");

endmodule

bind rv_front_top rv_front_sva rv_front_sva_inst (
  .clk            (clk),
  .rst_i          (rst_i),
  .wb_cyc_o       (wb_cyc_o),
  .wb_stb_o       (wb_stb_o),
  .wb_adr_o       (wb_adr_o),
  .wb_ack_i       (wb_ack_i),
  .wb_err_i       (wb_err_i),
  .rename_stall_i (rename_stall_i),
  .rename_valid_o (rename_valid_o),
  .addr_o         (addr_o),
  .imm_o          (imm_o),
  .rd_o           (rd_o),
  .rsop_o         (rsop_o)
);

/* tb_rv_front.sv */
// testbench for the front end: wishbone memory model, program generator and decode checker
`timescale 1ns/100ps

module tb_rv_front;
  import rv_front_pkg::*;

  localparam int N_SEQ = 40;
  localparam int N_ILL = 20;
  localparam int N_STALL = 60;
  localparam int N_ROB = 20;
  localparam int N_FLUSH = 19;
  localparam int TOTAL_INSN = N_SEQ + N_ILL + N_STALL + N_ROB + N_FLUSH;
  localparam logic [31:0] LFSR_SEED = 32'd87246;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  typedef struct packed {
    logic     err;
    ecause_t  cause;
    word_t    imm;
    pc_t      target;
    rd_tag_t  rd;
    rsop_t    rsop;
    retop_t   retop;
    logic [5:0] uses;
  } dec_t;

  logic clk, rst_i;
  logic wb_cyc_o, wb_stb_o, wb_ack_i, wb_err_i;
  pc_t wb_adr_o;
  word_t wb_dat_i;
  logic flush_i, retire_i, rename_stall_i;
  pc_t flush_target_i;
  logic rob_full_o, rob_valid_o, rename_valid_o, error_o;
  robid_t robid_o;
  ecause_t ecause_o;
  retop_t retop_o;
  pc_t addr_o, target_o;
  rd_tag_t rd_o;
  rsop_t rsop_o;
  reg_idx_t rs1_o, rs2_o;
  word_t imm_o;
  logic uses_rs1_o, uses_rs2_o, uses_imm_o, uses_memory_o, uses_pc_o, csr_access_o;

  word_t mem [256];
  logic mem_err [256];
  logic [31:0] wb_lfsr, stall_lfsr, prog_lfsr;
  int errors, tests_run, tcount, total_insn, mark_err, mark_insn;
  int wait_left;
  logic in_cycle, auto_retire, stall_en;
  pc_t exp_pc;
  robid_t exp_id;

  rv_front_top rv_front_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(TOTAL_INSN * 40 * 20);
    $display("timeout: expected instructions were not accepted in time");
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic logic [31:0] lfsr_take(inout logic [31:0] st, input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], st[0]};
      st = st[0] ? ((st >> 1) ^ LFSR_TAPS) : (st >> 1);
    end
    return v;
  endfunction

  function automatic opcode_t pick_opcode(logic [3:0] n);
    case (n % 11)
      0: return OPC_LOAD;
      1: return OPC_MISCMEM;
      2: return OPC_OPIMM;
      3: return OPC_AUIPC;
      4: return OPC_STORE;
      5: return OPC_OP;
      6: return OPC_LUI;
      7: return OPC_BRANCH;
      8: return OPC_JALR;
      9: return OPC_JAL;
      default: return OPC_SYSTEM;
    endcase
  endfunction

  // expected decode of one word fetched from address a
  function automatic dec_t ref_decode(word_t w, pc_t a, logic bus_err);
    opcode_t opc;
    logic [2:0] f3;
    logic r, i, s, b, u, j, legal, csr, jalr, mem_op;
    dec_t d;
    opc = w[6:2];
    f3 = w[14:12];
    r = (opc == OPC_OP);
    i = (opc == OPC_OPIMM) || (opc == OPC_LOAD) || (opc == OPC_JALR)
      || (opc == OPC_MISCMEM) || (opc == OPC_SYSTEM);
    s = (opc == OPC_STORE);
    b = (opc == OPC_BRANCH);
    u = (opc == OPC_LUI) || (opc == OPC_AUIPC);
    j = (opc == OPC_JAL);
    legal = (w[1:0] == 2'b11) && (r || i || s || b || u || j);
    jalr = (opc == OPC_JALR);
    csr = (opc == OPC_SYSTEM) && (f3[1:0] != 2'b00);
    mem_op = (opc == OPC_LOAD) || s;
    d = '0;
    d.err = bus_err || !legal;
    if (bus_err) begin
      d.cause = a[1] ? ERR_IALIGN : ERR_IFAULT;
    end else begin
      d.cause = ERR_IILLEGAL;
    end
    if (i) d.imm = {{20{w[31]}}, w[31:20]};
    if (s) d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
    if (b) d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    if (u) d.imm = {w[31:12], 12'd0};
    if (j) d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    d.target = a + d.imm;
    d.rd = {!((r || i || u || j) && (w[11:7] != 5'd0)), w[11:7]};
    if (mem_op) d.rsop = {1'b0, s, f3};
    else if (r && w[25]) d.rsop = {2'b11, f3};
    else if (jalr) d.rsop = 5'b10000;
    else if (b) d.rsop = {2'b01, !(f3[2] || f3[1]), f3[2:1]};
    else d.rsop = {1'b0, (r || (f3 == 3'd5)) && w[30], f3};
    d.retop = {b, f3[0], jalr, s, f3};
    d.uses = {r || (i && !(csr && f3[2])) || s || b, r || s || b, !r && !b,
              mem_op, j || jalr || (opc == OPC_AUIPC), csr};
    return d;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h expected %h (insn at %h)", name, got, exp, exp_pc);
    end
  endtask

  task automatic check_insn();
    dec_t d;
    word_t w;
    logic bus_err;
    w = mem[exp_pc[9:2]];
    bus_err = exp_pc[1] || mem_err[exp_pc[9:2]];
    d = ref_decode(w, exp_pc, bus_err);
    check_val("addr_o", addr_o, exp_pc);
    check_val("robid_o", robid_o, exp_id);
    check_val("error_o", error_o, d.err);
    check_val("rename_valid_o", rename_valid_o, !d.err);
    if (d.err) begin
      check_val("ecause_o", ecause_o, d.cause);
    end else begin
      check_val("imm_o", imm_o, d.imm);
      check_val("target_o", target_o, d.target);
      check_val("rd_o", rd_o, d.rd);
      check_val("rs1_o", rs1_o, w[19:15]);
      check_val("rs2_o", rs2_o, w[24:20]);
      check_val("rsop_o", rsop_o, d.rsop);
      check_val("retop_o", retop_o, d.retop);
      check_val("uses_o", {uses_rs1_o, uses_rs2_o, uses_imm_o, uses_memory_o,
                uses_pc_o, csr_access_o}, d.uses);
    end
    exp_pc = exp_pc + 32'd4;
    exp_id = exp_id + 1'b1;
    tcount++;
    total_insn++;
  endtask

  // accepts in a flush cycle belong to the squashed path
  always @(posedge clk) begin
    if (!rst_i && !flush_i && rob_valid_o && !rob_full_o) begin
      check_insn();
    end
  end

  // wishbone slave with 0 to 2 wait cycles
  always @(posedge clk) begin
    if (rst_i) begin
      wb_ack_i <= 1'b0;
      wb_err_i <= 1'b0;
      in_cycle = 1'b0;
    end else if (wb_ack_i || wb_err_i) begin
      wb_ack_i <= 1'b0;
      wb_err_i <= 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!in_cycle) begin
        in_cycle = 1'b1;
        wait_left = lfsr_take(wb_lfsr, 2) % 3;
      end
      if (wait_left == 0) begin
        in_cycle = 1'b0;
        wb_dat_i <= mem[wb_adr_o[9:2]];
        if (mem_err[wb_adr_o[9:2]]) wb_err_i <= 1'b1;
        else wb_ack_i <= 1'b1;
      end else begin
        wait_left--;
      end
    end
  end

  always @(posedge clk) begin
    if (stall_en) rename_stall_i <= (lfsr_take(stall_lfsr, 1) != 0);
    else rename_stall_i <= 1'b0;
  end

  // free one entry whenever the buffer fills
  always @(posedge clk) begin
    if (auto_retire) retire_i <= rob_full_o;
  end

  task automatic fill_program(input logic mixed);
    int k;
    word_t w;
    for (k = 0; k < 256; k++) begin
      w = lfsr_take(prog_lfsr, 32);
      if (!mixed || lfsr_take(prog_lfsr, 1) != 0) begin
        w[6:0] = {pick_opcode(lfsr_take(prog_lfsr, 4)), 2'b11};
      end
      mem[k] = w;
      mem_err[k] = 1'b0;
    end
  endtask

  task automatic do_flush(input pc_t target);
    @(posedge clk);
    flush_i <= 1'b1;
    flush_target_i <= target;
    @(posedge clk);
    flush_i <= 1'b0;
    exp_pc = target;
    exp_id = '0;
    tcount = 0;
  endtask

  task automatic wait_count(input int n);
    while (tcount < n) @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d instructions, %0d errors", tests_run, name,
             total_insn - mark_insn, errors - mark_err);
    mark_err = errors;
    mark_insn = total_insn;
  endtask

  initial begin
    int k;
    rst_i = 1'b1;
    flush_i = 1'b0;
    flush_target_i = '0;
    retire_i = 1'b0;
    rename_stall_i = 1'b0;
    wb_dat_i = '0;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    wb_lfsr = LFSR_SEED;
    stall_lfsr = LFSR_SEED;
    prog_lfsr = LFSR_SEED;
    {errors, tests_run, tcount, total_insn, mark_err, mark_insn} = '0;
    auto_retire = 1'b1;
    stall_en = 1'b0;
    exp_pc = RESET_PC;
    exp_id = '0;
    fill_program(1'b0);
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;

    wait_count(N_SEQ);
    finish_test("sequential fetch");

    // compressed and custom words, then a bus fault at the end
    for (k = 0; k < N_ILL; k++) begin
      if (k % 3 == 0) mem[64 + k][1:0] = 2'b01;
      if (k % 3 == 1) mem[64 + k][6:0] = 7'b0001011;
    end
    mem_err[64 + N_ILL - 1] = 1'b1;
    do_flush(32'h100);
    wait_count(N_ILL);
    finish_test("illegal and fault");

    fill_program(1'b1);
    @(negedge clk) stall_en = 1'b1;
    do_flush(32'h0);
    wait_count(N_STALL);
    @(negedge clk) stall_en = 1'b0;
    finish_test("back-pressure");

    @(negedge clk) auto_retire = 1'b0;
    @(posedge clk) retire_i <= 1'b0;
    do_flush(32'h40);
    wait_count(16);
    repeat (6) @(negedge clk);
    if (tcount != 16 || !rob_full_o) begin
      errors++;
      $display("rob full: %0d accepted without retire, full flag %b", tcount, rob_full_o);
    end
    for (k = 0; k < N_ROB - 16; k++) begin
      @(posedge clk) retire_i <= 1'b1;
      @(posedge clk) retire_i <= 1'b0;
      wait_count(17 + k);
      repeat (4) @(negedge clk);
      if (tcount != 17 + k) begin
        errors++;
        $display("rob full: retire pulse let %0d instructions through", tcount - 16 - k);
      end
    end
    @(negedge clk) auto_retire = 1'b1;
    finish_test("rob full");

    do_flush(32'h40);
    wait_count(8);
    do_flush(32'h300);
    wait_count(10);
    do_flush(32'h102);
    wait_count(1);
    repeat (20) @(negedge clk);
    if (tcount != 1) begin
      errors++;
      $display("misaligned redirect gave %0d instructions instead of one", tcount);
    end
    finish_test("flush and redirect");

    $display("tests %0d, instructions %0d, errors %0d", tests_run, total_insn, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* flist.f */
rv_front_pkg.sv
front_ctrl.sv
insn_fetch.sv
insn_decode.sv
rob_alloc.sv
rv_front_top.sv
rv_front_sva.sv
tb_rv_front.sv
